// File: rtl/loader_pkg.sv
package loader_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths that carry a meaning

	typedef logic [24:0]  dl_addr_t;   // Host download byte address
	typedef logic [22:0]  mem_addr_t;  // Word address inside one 8 MB bank
	typedef logic [7:0]   byte_t;
	typedef logic [8:0]   page_t;      // Bit 8 picks the upper half of a bank
	typedef logic [1:0]   bank_t;
	typedef logic [23:0]  file_ext_t;  // Three ASCII characters
	typedef logic [255:0] rom_map_t;   // One bit per upper ROM page

	typedef enum logic [1:0] {
		IDLE,
		SYS_LOAD,
		EXT_LOAD,
		TAPE_LOAD
	} loader_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Download index codes from the host menu

	localparam byte_t ROM_INDEX  = 8'd0;
	localparam byte_t EXT_INDEX  = 8'd3;
	localparam byte_t TAPE_INDEX = 8'd4;

	////////////////////////////////////////////////////////////////////////////
	// Fixed slots in a bank
	// Lower 4 MB holds OS ROM, RAM pages and the MF2 ROM
	// Upper 4 MB holds up to 256 pages of upper ROM

	localparam page_t OS_SLOT      = 9'h000;
	localparam page_t BASIC_SLOT   = 9'h100;
	localparam page_t AMSDOS_SLOT  = 9'h107;
	localparam page_t MF2_SLOT     = 9'h0FF;
	localparam page_t UNUSED_PAGE  = 9'h1EE; // Target for a malformed extension
	localparam page_t ROM_LOW_FILL = 9'h1FF;

	localparam int unsigned SYS_IMAGE_COUNT = 8; // Four images per model

endpackage

// File: rtl/boot_bus_if.sv
`timescale 1ns/100ps

// ROM write port towards external memory
// One cycle per write, no back-pressure
interface boot_bus_if import loader_pkg::*; ();

	logic      wr;
	mem_addr_t addr;
	bank_t     bank;
	byte_t     data;

	modport source (
		output wr, addr, bank, data
	);

	modport sink (
		input wr, addr, bank, data
	);

endinterface

// File: rtl/tape_mem_if.sv
`timescale 1ns/100ps

// Tape port towards external memory
// Access is pending while wr or rd is high, one ack toggle completes it
interface tape_mem_if import loader_pkg::*; ();

	mem_addr_t addr;
	logic      wr;
	logic      rd;
	byte_t     din;
	byte_t     dout;  // Valid in the cycle ack toggles
	logic      ack;

	modport master (
		output addr, wr, rd, din,
		input  dout, ack
	);

	modport slave (
		input  addr, wr, rd, din,
		output dout, ack
	);

endinterface

// File: rtl/loader_ctrl.sv
`timescale 1ns/100ps

module loader_ctrl import loader_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  dl_active,
	input  byte_t dl_index,
	input  logic  cfg_cpc664,
	output logic  sys_load,
	output logic  ext_load,
	output logic  tape_load,
	output logic  busy,
	output logic  ext_start,
	output logic  loader_reset,
	output logic  model
);

	loader_state_t state;
	loader_state_t start_state;
	logic          active_d;
	logic          dl_rise;

	assign dl_rise = dl_active & ~active_d;

	// Kind of download, picked from the host index
	always_comb begin
		case (dl_index)
			ROM_INDEX:  start_state = SYS_LOAD;
			EXT_INDEX:  start_state = EXT_LOAD;
			TAPE_INDEX: start_state = TAPE_LOAD;
			default:    start_state = IDLE;   // Unknown index is ignored
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= IDLE;
			active_d     <= 1'b0;
			ext_start    <= 1'b0;
			loader_reset <= 1'b0;
		end else begin
			active_d     <= dl_active;
			ext_start    <= dl_rise && (dl_index == EXT_INDEX);
			loader_reset <= sys_load | ext_load;  // Machine held while ROMs change

			if (!dl_active)
				state <= IDLE;
			else if (dl_rise)
				state <= start_state;
		end
	end

	assign sys_load  = (state == SYS_LOAD);
	assign ext_load  = (state == EXT_LOAD);
	assign tape_load = (state == TAPE_LOAD);
	assign busy      = (state != IDLE);

	// Model only changes across a reset of the machine
	always_ff @(posedge clk_sys) begin
		if (reset || loader_reset)
			model <= cfg_cpc664;
	end

endmodule

// File: rtl/expansion_page_decoder.sv
`timescale 1ns/100ps

module expansion_page_decoder import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      ext_start,
	input  file_ext_t dl_file_ext,
	output page_t     page
);

	// Returns {valid, nibble} for one hex character
	function automatic logic [4:0] hex_value(input byte_t c);
		logic [4:0] v;
		v = 5'd0;
		if (c >= "0" && c <= "9")
			v = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			v = {1'b1, c[3:0] + 4'd9};  // 'A' is 0x41
		return v;
	endfunction

	logic [4:0] hi_digit;
	logic [4:0] lo_digit;
	page_t      next_page;

	assign hi_digit = hex_value(dl_file_ext[15:8]);
	assign lo_digit = hex_value(dl_file_ext[7:0]);

	always_comb begin
		next_page = UNUSED_PAGE;
		if (hi_digit[4])
			next_page[7:4] = hi_digit[3:0];
		if (lo_digit[4])
			next_page[3:0] = lo_digit[3:0];
		if (dl_file_ext[15:0] == "ZZ")
			next_page = '0;                 // Lower half, page 0
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			page <= UNUSED_PAGE;
		else if (ext_start)
			page <= next_page;
	end

endmodule

// File: rtl/boot_write_mux.sv
`timescale 1ns/100ps

module boot_write_mux import loader_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     sys_load,
	input  logic     ext_load,
	input  logic     model,
	input  dl_addr_t dl_addr,
	input  byte_t    dl_data,
	input  logic     dl_wr,
	input  page_t    page,
	boot_bus_if.source boot,
	output rom_map_t rom_map
);

	logic [10:0] image;     // 16 KB image number of a system download
	page_t       slot;
	bank_t       bank;
	logic        slot_ok;
	logic        wr_d;
	logic [7:0]  map_page;
	logic        map_hit;

	assign image = dl_addr[24:14];

	////////////////////////////////////////////////////////////////////////////
	// Address mapping

	always_comb begin
		slot    = ROM_LOW_FILL;
		bank    = '0;
		slot_ok = 1'b0;
		if (ext_load) begin
			slot    = {page[8], page[7:0] + dl_addr[21:14]};
			bank    = {1'b0, model};
			slot_ok = 1'b1;
		end else if (sys_load) begin
			case (image)
				11'd0, 11'd4: slot = OS_SLOT;
				11'd1, 11'd5: slot = BASIC_SLOT;
				11'd2, 11'd6: slot = AMSDOS_SLOT;
				11'd3, 11'd7: slot = MF2_SLOT;
				default:      slot = ROM_LOW_FILL;
			endcase
			bank    = {1'b0, image[2]};  // Images 4..7 belong to the 664
			slot_ok = (image < SYS_IMAGE_COUNT);
		end
	end

	assign boot.wr   = dl_wr & slot_ok;
	assign boot.addr = {slot, dl_addr[13:0]};
	assign boot.bank = bank;
	assign boot.data = dl_data;

	////////////////////////////////////////////////////////////////////////////
	// Upper ROM page map

	always_ff @(posedge clk_sys) begin
		if (dl_wr)
			map_page <= slot[7:0];          // Held for the end of the write
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_d    <= 1'b0;
			map_hit <= 1'b0;
			rom_map <= '0;
		end else begin
			wr_d <= dl_wr;
			if (dl_wr)
				map_hit <= slot_ok & slot[8];
			if (wr_d && !dl_wr && map_hit)
				rom_map[map_page] <= 1'b1;
		end
	end

endmodule

// File: rtl/tape_buffer_player.sv
`timescale 1ns/100ps

module tape_buffer_player import loader_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     tape_load,
	input  logic     busy,
	input  dl_addr_t dl_addr,
	input  byte_t    dl_data,
	input  logic     dl_wr,
	input  logic     tape_data_req,
	tape_mem_if.master mem,
	output logic     tape_data_ack,
	output byte_t    tape_data,
	output logic     tape_end
);

	mem_addr_t play_addr;
	mem_addr_t last_addr;
	mem_addr_t addr_q;
	byte_t     din_q;
	logic      wr_q;
	logic      rd_q;
	logic      wr_d;
	logic      ack_d;
	logic      ack_edge;
	logic      req_pending;

	assign ack_edge    = mem.ack ^ ack_d;
	assign req_pending = tape_data_req ^ tape_data_ack;

	assign mem.addr = addr_q;
	assign mem.din  = din_q;
	assign mem.wr   = wr_q;
	assign mem.rd   = rd_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q          <= 1'b0;
			rd_q          <= 1'b0;
			wr_d          <= 1'b0;
			ack_d         <= 1'b0;
			tape_end      <= 1'b0;
			tape_data_ack <= tape_data_req;  // Nothing pending out of reset
			play_addr     <= 23'd1;          // Empty tape until a download
			last_addr     <= '0;
		end else begin
			wr_d  <= dl_wr;
			ack_d <= mem.ack;

			//////////////////////////////////////////////////////////////////
			// Download side

			if (wr_q && ack_edge)
				wr_q <= 1'b0;

			if (tape_load) begin
				play_addr <= '0;
				tape_end  <= 1'b0;
				if (dl_wr && !wr_d) begin
					wr_q      <= 1'b1;
					addr_q    <= dl_addr[22:0];
					din_q     <= dl_data;
					last_addr <= dl_addr[22:0];
				end
			end

			//////////////////////////////////////////////////////////////////
			// Playback side

			if (rd_q && ack_edge) begin
				rd_q          <= 1'b0;
				tape_data     <= mem.dout;
				tape_data_ack <= tape_data_req;
				play_addr     <= play_addr + 23'd1;
			end else if (!busy && !rd_q && !wr_q && req_pending) begin
				if (play_addr <= last_addr) begin
					rd_q   <= 1'b1;
					addr_q <= play_addr;
				end else begin
					tape_end <= 1'b1;            // Request left unanswered
				end
			end
		end
	end

endmodule

// File: rtl/cpc_loader_top.sv
`timescale 1ns/100ps

module cpc_loader_top import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,

	// Host download stream
	input  logic      dl_active,
	input  byte_t     dl_index,
	input  file_ext_t dl_file_ext,
	input  dl_addr_t  dl_addr,
	input  byte_t     dl_data,
	input  logic      dl_wr,
	input  logic      cfg_cpc664,

	output logic      loader_reset,
	output logic      model,

	// ROM writes to memory
	output logic      boot_wr,
	output mem_addr_t boot_addr,
	output bank_t     boot_bank,
	output byte_t     boot_data,
	output rom_map_t  rom_map,

	// Tape port of memory
	output mem_addr_t tape_addr,
	output logic      tape_wr,
	output logic      tape_rd,
	output byte_t     tape_din,
	input  byte_t     tape_dout,
	input  logic      tape_ack,

	// Tape consumer
	input  logic      tape_data_req,
	output logic      tape_data_ack,
	output byte_t     tape_data,
	output logic      tape_end
);

	logic  sys_load;
	logic  ext_load;
	logic  tape_load;
	logic  busy;
	logic  ext_start;
	page_t page;

	boot_bus_if boot_bus ();
	tape_mem_if tape_mem ();

	loader_ctrl ctrl_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.cfg_cpc664   (cfg_cpc664),
		.sys_load     (sys_load),
		.ext_load     (ext_load),
		.tape_load    (tape_load),
		.busy         (busy),
		.ext_start    (ext_start),
		.loader_reset (loader_reset),
		.model        (model)
	);

	expansion_page_decoder page_dec_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ext_start   (ext_start),
		.dl_file_ext (dl_file_ext),
		.page        (page)
	);

	boot_write_mux boot_mux_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sys_load (sys_load),
		.ext_load (ext_load),
		.model    (model),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.dl_wr    (dl_wr),
		.page     (page),
		.boot     (boot_bus.source),
		.rom_map  (rom_map)
	);

	tape_buffer_player tape_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.tape_load     (tape_load),
		.busy          (busy),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.dl_wr         (dl_wr),
		.tape_data_req (tape_data_req),
		.mem           (tape_mem.master),
		.tape_data_ack (tape_data_ack),
		.tape_data     (tape_data),
		.tape_end      (tape_end)
	);

	assign boot_wr   = boot_bus.wr;
	assign boot_addr = boot_bus.addr;
	assign boot_bank = boot_bus.bank;
	assign boot_data = boot_bus.data;

	assign tape_addr     = tape_mem.addr;
	assign tape_wr       = tape_mem.wr;
	assign tape_rd       = tape_mem.rd;
	assign tape_din      = tape_mem.din;
	assign tape_mem.dout = tape_dout;
	assign tape_mem.ack  = tape_ack;

endmodule

// File: verification/loader_mem_model.sv
`timescale 1ns/100ps

// Tape memory with random latency, plus the tape consumer
module loader_mem_model import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      slow,
	input  mem_addr_t tape_addr,
	input  logic      tape_wr,
	input  logic      tape_rd,
	input  byte_t     tape_din,
	output byte_t     tape_dout,
	output logic      tape_ack,
	output logic      tape_data_req,
	input  logic      tape_data_ack,
	input  byte_t     tape_data
);

	byte_t       mem [0:255];
	logic [31:0] rng = 32'h54aa;
	logic        served;
	int          count;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		tape_data_req = 1'b0;
		tape_dout     = 8'h00;
		tape_ack      = 1'b0;
	end

	always @(posedge clk_sys) begin
		if (reset || (!tape_wr && !tape_rd)) begin
			if (reset)
				tape_ack <= 1'b0;
			served <= 1'b0;
			count  <= -1;
		end else if (!served) begin
			if (count < 0) begin
				rng = xorshift(rng);
				count <= slow ? int'(rng % 12) : int'(rng % 4);  // Access latency
			end else if (count == 0) begin
				tape_ack <= ~tape_ack;
				served   <= 1'b1;
				if (tape_wr)
					mem[tape_addr[7:0]] <= tape_din;
				else
					tape_dout <= mem[tape_addr[7:0]];
			end else
				count <= count - 1;
		end
	end

	// New request towards the player
	task automatic raise_request();
		if (tape_data_req == tape_data_ack)
			tape_data_req <= ~tape_data_req;  // Only when nothing is pending
	endtask

	// Answer to the request in flight, or ok low after a long silence
	task automatic wait_answer(output logic ok, output byte_t data);
		int waited;
		ok     = 1'b0;
		waited = 0;
		@(posedge clk_sys);
		while (!ok && waited < 100) begin
			@(posedge clk_sys);
			waited++;
			ok = (tape_data_req == tape_data_ack);
		end
		data = tape_data;
	endtask

	// One byte from the player, after a random gap
	task automatic consume(output logic ok, output byte_t data);
		rng = xorshift(rng);
		repeat (slow ? rng % 10 : rng % 3) @(posedge clk_sys);
		@(posedge clk_sys);
		raise_request();
		wait_answer(ok, data);
	endtask

endmodule

// File: verification/cpc_loader_tb.sv
`timescale 1ns/100ps

module cpc_loader_tb import loader_pkg::*; ();

	localparam int CHK_MAP   = 0;
	localparam int CHK_MODEL = 1;
	localparam int CHK_END   = 2;

	logic clk_sys, reset, dl_active, dl_wr, cfg_cpc664, slow;
	byte_t dl_index, dl_data, boot_data, tape_din, tape_dout, tape_data, got_data, exp_tape;
	file_ext_t dl_file_ext;
	dl_addr_t dl_addr;
	logic loader_reset, model, boot_wr, tape_wr, tape_rd, tape_ack, tape_data_req;
	logic tape_data_ack, tape_end;
	mem_addr_t boot_addr, tape_addr, exp_addr;
	bank_t boot_bank, exp_bank;
	rom_map_t rom_map, exp_map;
	logic exp_wr, exp_model, rom_dl, check_map, check_model, check_end, got_valid, got_ok;
	page_t cur_page;
	logic [31:0] rng = 32'h54aa;
	byte_t tape_q [$];

	cpc_loader_top dut_i (.*);

	loader_mem_model mem_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	a_boot_wr: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> boot_wr == exp_wr)
		else begin
			$display("[ERROR] %0t boot_wr got %b expected %b", $time, $sampled(boot_wr),
				$sampled(exp_wr));
			stop_run();
		end
	a_boot_addr: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr && exp_wr |-> boot_addr == exp_addr && boot_bank == exp_bank
			&& boot_data == dl_data)
		else begin
			$display("[ERROR] %0t boot_addr/bank/data got %h/%0d/%h expected %h/%0d/%h", $time,
				$sampled(boot_addr), $sampled(boot_bank), $sampled(boot_data),
				$sampled(exp_addr), $sampled(exp_bank), $sampled(dl_data));
			stop_run();
		end
	a_held: assert property (@(posedge clk_sys) disable iff (reset)
		rom_dl && dl_wr |-> loader_reset)
		else begin
			$display("[ERROR] %0t loader_reset got 0 expected 1", $time);
			stop_run();
		end
	a_map: assert property (@(posedge clk_sys) check_map |-> rom_map == exp_map)
		else begin
			$display("[ERROR] %0t rom_map got %h expected %h", $time, $sampled(rom_map),
				$sampled(exp_map));
			stop_run();
		end
	a_model: assert property (@(posedge clk_sys) check_model |-> model == exp_model)
		else begin
			$display("[ERROR] %0t model got %b expected %b", $time, $sampled(model),
				$sampled(exp_model));
			stop_run();
		end
	a_byte: assert property (@(posedge clk_sys) got_valid |-> got_ok && got_data == exp_tape)
		else begin
			$display("[ERROR] %0t tape_data got %h expected %h", $time, $sampled(got_data),
				$sampled(exp_tape));
			stop_run();
		end
	a_end: assert property (@(posedge clk_sys) check_end |-> tape_end && !got_ok)
		else begin
			$display("Tape end not flagged, or a request past the end was answered");
			stop_run();
		end
	a_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		tape_end |=> $stable(tape_data_ack))
		else begin
			$display("Consumer answered after the end of the tape");
			stop_run();
		end
	a_once: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(tape_data_ack) |-> tape_data_ack == tape_data_req)
		else begin
			$display("Consumer answered a request that was not pending");
			stop_run();
		end
	a_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(tape_wr && tape_rd))
		else begin
			$display("Tape write and read were issued together");
			stop_run();
		end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and stimulus

	function automatic logic [4:0] hex_digit(input byte_t c);
		if (c >= "0" && c <= "9")
			return {1'b1, 4'(c - "0")};
		if (c >= "A" && c <= "F")
			return {1'b1, 4'(c - "A" + 10)};
		return 5'd0;
	endfunction

	function automatic page_t ext_page(input logic [15:0] ext);
		page_t      p;
		logic [4:0] hi;
		logic [4:0] lo;
		p  = UNUSED_PAGE;
		hi = hex_digit(ext[15:8]);
		lo = hex_digit(ext[7:0]);
		if (ext == "ZZ")
			return 9'h000;
		if (hi >= 5'h10)
			p[7:4] = hi[3:0];
		if (lo >= 5'h10)
			p[3:0] = lo[3:0];
		return p;
	endfunction

	task automatic start_dl(input byte_t idx, input file_ext_t ext);
		@(posedge clk_sys);
		dl_active   <= 1'b1;
		dl_index    <= idx;
		dl_file_ext <= ext;
		rom_dl      <= (idx != TAPE_INDEX);
		if (idx != TAPE_INDEX)
			exp_model <= cfg_cpc664;       // Latched during the loader reset
		cur_page = ext_page(ext[15:0]);
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic end_dl();
		@(posedge clk_sys);
		dl_active <= 1'b0;
		rom_dl    <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic dl_write(input dl_addr_t a, input byte_t d);
		int n;
		int waited;
		page_t slot;
		n = a[24:14];
		slot = (n % 4 == 0) ? OS_SLOT : (n % 4 == 1) ? BASIC_SLOT :
			(n % 4 == 2) ? AMSDOS_SLOT : MF2_SLOT;
		if (dl_index == EXT_INDEX)
			slot = {cur_page[8], cur_page[7:0] + a[21:14]};
		@(posedge clk_sys);
		dl_addr  <= a;
		dl_data  <= d;
		dl_wr    <= 1'b1;
		exp_wr   <= (dl_index == EXT_INDEX) || (dl_index == ROM_INDEX && n < 8);
		exp_addr <= {slot, a[13:0]};
		exp_bank <= (dl_index == EXT_INDEX) ? {1'b0, exp_model} : bank_t'(n >= 4);
		if ((dl_index == EXT_INDEX || (dl_index == ROM_INDEX && n < 8)) && slot[8])
			exp_map[slot[7:0]] = 1'b1;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		repeat (2) @(posedge clk_sys);
		waited = 0;
		while (tape_wr && waited < 100) begin
			@(posedge clk_sys);
			waited++;
		end
		if (tape_wr) begin
			$display("Tape write was never acknowledged by memory");
			stop_run();
		end
	endtask

	// One-cycle strobe for a check of settled state
	task automatic pulse_check(input int kind);
		repeat (2) @(posedge clk_sys);
		case (kind)
			CHK_MAP:   check_map   <= 1'b1;
			CHK_MODEL: check_model <= 1'b1;
			default:   check_end   <= 1'b1;
		endcase
		@(posedge clk_sys);
		check_map   <= 1'b0;
		check_model <= 1'b0;
		check_end   <= 1'b0;
	endtask

	task automatic tape_round(input int count);
		logic  ok;
		logic  early;
		byte_t d;
		start_dl(TAPE_INDEX, "TAP");
		mem_i.raise_request();             // Held off until the download ends
		for (int i = 0; i < count; i++) begin
			rng = mem_i.xorshift(rng);
			tape_q.push_back(rng[7:0]);
			dl_write(dl_addr_t'(i), rng[7:0]);
		end
		end_dl();
		early = 1'b1;
		while (tape_q.size() > 0) begin
			if (early)
				mem_i.wait_answer(ok, d);
			else
				mem_i.consume(ok, d);
			early = 1'b0;
			if (!ok) begin
				$display("Consumer got no answer while bytes were left");
				stop_run();
			end
			got_valid <= 1'b1;
			got_ok    <= ok;
			got_data  <= d;
			exp_tape  <= tape_q.pop_front();
			@(posedge clk_sys);
			got_valid <= 1'b0;
		end
		mem_i.consume(ok, d);              // One request past the end
		got_ok <= ok;
		pulse_check(CHK_END);
	endtask

	initial begin
		{dl_active, dl_wr, cfg_cpc664, slow, rom_dl, exp_wr, exp_model} = '0;
		{check_map, check_model, check_end, got_valid, got_ok} = '0;
		{dl_index, dl_data, got_data, exp_tape, exp_bank, exp_addr} = '0;
		{dl_file_ext, dl_addr, exp_map, cur_page} = '0;
		reset = 1'b1;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;

		start_dl(ROM_INDEX, "ROM");          // System images 0..8
		for (int n = 0; n <= 8; n++)
			for (int o = 0; o < 3; o++)
				dl_write({11'(n), 14'(o * 8191)}, 8'(n * 16 + o));
		end_dl();
		pulse_check(CHK_MAP);

		start_dl(EXT_INDEX, "R05");
		for (int p = 0; p < 2; p++)
			dl_write({3'd0, 8'(p), 14'h0123}, 8'hA0 + 8'(p));
		end_dl();
		start_dl(EXT_INDEX, "R1A");
		for (int p = 0; p < 2; p++)
			dl_write({3'd0, 8'(p), 14'h3FFF}, 8'hB0 + 8'(p));
		end_dl();
		start_dl(EXT_INDEX, "RQ?");
		dl_write(25'h0000042, 8'hC1);
		end_dl();
		start_dl(EXT_INDEX, "RZZ");
		dl_write(25'h0004007, 8'hC2);
		end_dl();
		pulse_check(CHK_MAP);

		cfg_cpc664 <= 1'b1;                  // Idle change must not reach model
		pulse_check(CHK_MODEL);
		start_dl(EXT_INDEX, "R20");
		dl_write(25'h0000010, 8'hD0);
		end_dl();
		pulse_check(CHK_MODEL);

		tape_round(16);

		reset <= 1'b1;                       // Clears the end of the first tape
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		exp_map   = '0;
		exp_model <= cfg_cpc664;
		slow      <= 1'b1;
		tape_round(24);
		pulse_check(CHK_MAP);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: all.f
rtl/loader_pkg.sv
rtl/boot_bus_if.sv
rtl/tape_mem_if.sv
rtl/loader_ctrl.sv
rtl/expansion_page_decoder.sv
rtl/boot_write_mux.sv
rtl/tape_buffer_player.sv
rtl/cpc_loader_top.sv
verification/loader_mem_model.sv
verification/cpc_loader_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test  - build with Verilator and run the testbench"
	@echo "make clean - remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpc_loader_tb \
		-f all.f -o sim
	-./obj_dir/sim > sim.log 2>&1
	@cat sim.log
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
